// ==== shader_num_pkg.sv ====
`default_nettype none

package shader_num_pkg;

    // default vertex coordinate width
    localparam int COORD_W = 16;

    // squared z is multiplied by 16 before the divide
    localparam int SCALE_SHIFT = 4;

    // table index covers 0 to 16
    localparam int INDEX_W = 5;

    // normal 2 + magnitude 2 + divider 6 + lut 1
    localparam int SHADE_LATENCY = 11;

    // edge vector, one bit more than a coordinate
    function automatic int edge_width(input int coord_w);
        return coord_w + 1;
    endfunction

    // cross product component
    function automatic int normal_width(input int coord_w);
        return 2 * coord_w + 3;
    endfunction

    // sum of three squared components
    function automatic int mag_width(input int coord_w);
        return 4 * coord_w + 8;
    endfunction

endpackage

`default_nettype wire

// ==== shader_color_pkg.sv ====
`default_nettype none

package shader_color_pkg;

    localparam int COLOR_W = 8;

    // floor(16 * cos^2) selects one entry
    localparam int TABLE_SIZE = 17;

    // grey ramp, top entry saturates at full white
    localparam logic [COLOR_W-1:0] SHADE_TABLE [0:TABLE_SIZE-1] = '{
        8'd0,   8'd20,  8'd40,  8'd60,
        8'd78,  8'd96,  8'd114, 8'd130,
        8'd146, 8'd162, 8'd178, 8'd194,
        8'd210, 8'd226, 8'd242, 8'd255,
        8'd255
    };

    // normal points away from the light
    localparam logic [COLOR_W-1:0] BACK_FACE_COLOR = 8'd255;

    // zero-area triangle
    localparam logic [COLOR_W-1:0] DEGENERATE_COLOR = 8'd0;

endpackage

`default_nettype wire

// ==== normal_unit.sv ====
`default_nettype none

module normal_unit #(
    parameter int COORD_W = shader_num_pkg::COORD_W,
    localparam int NORM_W = shader_num_pkg::normal_width(COORD_W)
) (
    input wire clk,
    input wire rst_in,
    input wire data_valid_in,
    input wire signed [COORD_W-1:0] v0_x,
    input wire signed [COORD_W-1:0] v0_y,
    input wire signed [COORD_W-1:0] v0_z,
    input wire signed [COORD_W-1:0] v1_x,
    input wire signed [COORD_W-1:0] v1_y,
    input wire signed [COORD_W-1:0] v1_z,
    input wire signed [COORD_W-1:0] v2_x,
    input wire signed [COORD_W-1:0] v2_y,
    input wire signed [COORD_W-1:0] v2_z,
    output logic normal_valid,
    output logic signed [NORM_W-1:0] norm_x,
    output logic signed [NORM_W-1:0] norm_y,
    output logic signed [NORM_W-1:0] norm_z
);

    localparam int EDGE_W = shader_num_pkg::edge_width(COORD_W);

    // edge vectors from vertex 0
    logic signed [EDGE_W-1:0] e1_x, e1_y, e1_z;
    logic signed [EDGE_W-1:0] e2_x, e2_y, e2_z;
    logic edge_valid;

    always_ff @(posedge clk) begin
        if (rst_in) begin
            edge_valid <= 1'b0;
            normal_valid <= 1'b0;
        end else begin
            edge_valid <= data_valid_in;
            normal_valid <= edge_valid;
        end
    end

    // stage 1, operands sign extend to the edge width
    always_ff @(posedge clk) begin
        e1_x <= v1_x - v0_x;
        e1_y <= v1_y - v0_y;
        e1_z <= v1_z - v0_z;
        e2_x <= v2_x - v0_x;
        e2_y <= v2_y - v0_y;
        e2_z <= v2_z - v0_z;
    end

    // stage 2, cross product e1 x e2
    // each product fits in NORM_W-1 bits so the difference cannot wrap
    always_ff @(posedge clk) begin
        norm_x <= e1_y * e2_z - e1_z * e2_y;
        norm_y <= e1_z * e2_x - e1_x * e2_z;
        norm_z <= e1_x * e2_y - e1_y * e2_x;
    end

endmodule

`default_nettype wire

// ==== magnitude_unit.sv ====
`default_nettype none

module magnitude_unit #(
    parameter int COORD_W = shader_num_pkg::COORD_W,
    localparam int NORM_W = shader_num_pkg::normal_width(COORD_W),
    localparam int MAG_W = shader_num_pkg::mag_width(COORD_W)
) (
    input wire clk,
    input wire rst_in,
    input wire normal_valid,
    input wire signed [NORM_W-1:0] norm_x,
    input wire signed [NORM_W-1:0] norm_y,
    input wire signed [NORM_W-1:0] norm_z,
    output logic mag_valid,
    output logic [MAG_W-1:0] mag_sq,
    output logic [MAG_W-1:0] scaled_z_sq,
    output logic facing_away,
    output logic degenerate
);

    localparam int SQ_W = 2 * NORM_W;

    // squares are never negative, top bit always clear
    logic [SQ_W-1:0] sq_x, sq_y, sq_z;
    logic z_negative;
    logic sq_valid;
    logic [MAG_W-1:0] mag_sum;

    assign mag_sum = MAG_W'(sq_x) + MAG_W'(sq_y) + MAG_W'(sq_z);

    always_ff @(posedge clk) begin
        if (rst_in) begin
            sq_valid <= 1'b0;
            mag_valid <= 1'b0;
        end else begin
            sq_valid <= normal_valid;
            mag_valid <= sq_valid;
        end
    end

    always_ff @(posedge clk) begin
        sq_x <= norm_x * norm_x;
        sq_y <= norm_y * norm_y;
        sq_z <= norm_z * norm_z;
        z_negative <= norm_z[NORM_W-1];
        // stage 2
        mag_sq <= mag_sum;
        scaled_z_sq <= MAG_W'(sq_z) << shader_num_pkg::SCALE_SHIFT;
        facing_away <= z_negative;
        degenerate <= (mag_sum == '0);
    end

endmodule

`default_nettype wire

// ==== shade_divider.sv ====
`default_nettype none

module shade_divider #(
    parameter int COORD_W = shader_num_pkg::COORD_W,
    localparam int MAG_W = shader_num_pkg::mag_width(COORD_W),
    localparam int INDEX_W = shader_num_pkg::INDEX_W
) (
    input wire clk,
    input wire rst_in,
    input wire mag_valid,
    input wire [MAG_W-1:0] mag_sq,
    input wire [MAG_W-1:0] scaled_z_sq,
    input wire facing_away,
    input wire degenerate,
    output logic index_valid,
    output logic [INDEX_W-1:0] shade_index,
    output logic facing_away_out,
    output logic degenerate_out
);

    // divisor is pre-shifted so the first trial tests the top quotient bit
    localparam int SH_W = MAG_W + INDEX_W - 1;
    localparam int CNT_W = $clog2(INDEX_W);

    logic busy;
    logic [CNT_W-1:0] bit_cnt;
    logic [SH_W-1:0] rem;
    logic [SH_W-1:0] div_sh;
    logic [SH_W:0] trial;
    logic load;

    assign load = mag_valid && !busy;

    // top bit set means the subtraction borrowed
    assign trial = {1'b0, rem} - {1'b0, div_sh};

    always_ff @(posedge clk) begin
        if (rst_in) begin
            busy <= 1'b0;
            bit_cnt <= '0;
            index_valid <= 1'b0;
        end else begin
            index_valid <= 1'b0;
            if (load) begin
                busy <= 1'b1;
                bit_cnt <= '0;
            end else if (busy) begin
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == CNT_W'(INDEX_W - 1)) begin
                    busy <= 1'b0;
                    index_valid <= 1'b1;
                end
            end
        end
    end

    // one quotient bit per cycle, msb first
    // a zero divisor runs anyway and gives all ones, the lut discards it
    always_ff @(posedge clk) begin
        if (load) begin
            rem <= SH_W'(scaled_z_sq);
            div_sh <= SH_W'(mag_sq) << (INDEX_W - 1);
            facing_away_out <= facing_away;
            degenerate_out <= degenerate;
        end else if (busy) begin
            shade_index <= {shade_index[INDEX_W-2:0], ~trial[SH_W]};
            if (!trial[SH_W]) begin
                rem <= trial[SH_W-1:0];
            end
            div_sh <= div_sh >> 1;
        end
    end

endmodule

`default_nettype wire

// ==== shade_lut.sv ====
`default_nettype none

module shade_lut #(
    localparam int INDEX_W = shader_num_pkg::INDEX_W,
    localparam int COLOR_W = shader_color_pkg::COLOR_W
) (
    input wire clk,
    input wire rst_in,
    input wire index_valid,
    input wire [INDEX_W-1:0] shade_index,
    input wire facing_away,
    input wire degenerate,
    output logic valid_out,
    output logic [COLOR_W-1:0] color_out
);

    always_ff @(posedge clk) begin
        if (rst_in) begin
            valid_out <= 1'b0;
            color_out <= '0;
        end else begin
            valid_out <= index_valid;
            if (index_valid) begin
                // degenerate wins over back face, its sign is meaningless
                if (degenerate) begin
                    color_out <= shader_color_pkg::DEGENERATE_COLOR;
                end else if (facing_away) begin
                    color_out <= shader_color_pkg::BACK_FACE_COLOR;
                end else begin
                    color_out <= shader_color_pkg::SHADE_TABLE[shade_index];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== flat_shader.sv ====
`default_nettype none

// valid_out follows data_valid_in by shader_num_pkg::SHADE_LATENCY cycles,
// a new triangle is only taken once the previous one has left
module flat_shader #(
    parameter int COORD_W = shader_num_pkg::COORD_W
) (
    input wire clk,
    input wire rst_in,
    input wire data_valid_in,
    input wire signed [COORD_W-1:0] v0_x,
    input wire signed [COORD_W-1:0] v0_y,
    input wire signed [COORD_W-1:0] v0_z,
    input wire signed [COORD_W-1:0] v1_x,
    input wire signed [COORD_W-1:0] v1_y,
    input wire signed [COORD_W-1:0] v1_z,
    input wire signed [COORD_W-1:0] v2_x,
    input wire signed [COORD_W-1:0] v2_y,
    input wire signed [COORD_W-1:0] v2_z,
    output logic valid_out,
    output logic [shader_color_pkg::COLOR_W-1:0] color_out
);

    localparam int NORM_W = shader_num_pkg::normal_width(COORD_W);
    localparam int MAG_W = shader_num_pkg::mag_width(COORD_W);

    logic normal_valid;
    logic signed [NORM_W-1:0] norm_x, norm_y, norm_z;

    logic mag_valid;
    logic [MAG_W-1:0] mag_sq, scaled_z_sq;
    logic facing_away, degenerate;

    logic index_valid;
    logic [shader_num_pkg::INDEX_W-1:0] shade_index;
    logic facing_away_div, degenerate_div;

    normal_unit #(.COORD_W(COORD_W)) i_normal (
        .clk(clk), .rst_in(rst_in), .data_valid_in(data_valid_in),
        .v0_x(v0_x), .v0_y(v0_y), .v0_z(v0_z),
        .v1_x(v1_x), .v1_y(v1_y), .v1_z(v1_z),
        .v2_x(v2_x), .v2_y(v2_y), .v2_z(v2_z),
        .normal_valid(normal_valid),
        .norm_x(norm_x), .norm_y(norm_y), .norm_z(norm_z)
    );

    magnitude_unit #(.COORD_W(COORD_W)) i_magnitude (
        .clk(clk), .rst_in(rst_in), .normal_valid(normal_valid),
        .norm_x(norm_x), .norm_y(norm_y), .norm_z(norm_z),
        .mag_valid(mag_valid), .mag_sq(mag_sq), .scaled_z_sq(scaled_z_sq),
        .facing_away(facing_away), .degenerate(degenerate)
    );

    shade_divider #(.COORD_W(COORD_W)) i_divider (
        .clk(clk), .rst_in(rst_in), .mag_valid(mag_valid),
        .mag_sq(mag_sq), .scaled_z_sq(scaled_z_sq),
        .facing_away(facing_away), .degenerate(degenerate),
        .index_valid(index_valid), .shade_index(shade_index),
        .facing_away_out(facing_away_div), .degenerate_out(degenerate_div)
    );

    shade_lut i_lut (
        .clk(clk), .rst_in(rst_in), .index_valid(index_valid),
        .shade_index(shade_index),
        .facing_away(facing_away_div), .degenerate(degenerate_div),
        .valid_out(valid_out), .color_out(color_out)
    );

endmodule

`default_nettype wire

// ==== tb_flat_shader.sv ====
`default_nettype none

module tb_flat_shader;

    localparam int COORD_W = shader_num_pkg::COORD_W;
    localparam int LATENCY = shader_num_pkg::SHADE_LATENCY;
    localparam int MAX_TRI = 64;

    logic clk;
    logic rst_in;
    logic data_valid_in;
    logic signed [COORD_W-1:0] v0_x, v0_y, v0_z;
    logic signed [COORD_W-1:0] v1_x, v1_y, v1_z;
    logic signed [COORD_W-1:0] v2_x, v2_y, v2_z;
    logic valid_out;
    logic [shader_color_pkg::COLOR_W-1:0] color_out;

    // nine coordinates and the expected color per triangle
    int tri_coord [0:MAX_TRI-1][0:8];
    int tri_color [0:MAX_TRI-1];
    int tri_count = 0;
    logic vectors_loaded = 1'b0;

    flat_shader #(.COORD_W(COORD_W)) i_dut (
        .clk(clk), .rst_in(rst_in), .data_valid_in(data_valid_in),
        .v0_x(v0_x), .v0_y(v0_y), .v0_z(v0_z),
        .v1_x(v1_x), .v1_y(v1_y), .v1_z(v1_z),
        .v2_x(v2_x), .v2_y(v2_y), .v2_z(v2_z),
        .valid_out(valid_out), .color_out(color_out)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic check_value(input string name, input int actual, input int expected);
        if (actual != expected) begin
            $display("FAILED at time %0t: %s = %0d, expected %0d",
                     $time, name, actual, expected);
            $display("Test failures found");
            $fatal(1);
        end
    endtask

    task automatic stop_with_error(input string reason);
        $display("%s", reason);
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic read_triangles();
        int fd;
        int fields;
        string line;
        int c [0:9];
        fd = $fopen("shader_stim.txt", "r");
        if (fd == 0) begin
            stop_with_error("could not open shader_stim.txt for reading");
        end
        while (!$feof(fd)) begin
            line = "";
            fields = $fgets(line, fd);
            if (fields == 0) begin
                break;
            end
            // skip comment and blank lines
            if (line.len() < 2 || line.getc(0) == 8'h23) begin
                continue;
            end
            fields = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d",
                             c[0], c[1], c[2], c[3], c[4], c[5], c[6], c[7], c[8], c[9]);
            if (fields != 10) begin
                stop_with_error("a line of shader_stim.txt does not hold ten numbers");
            end
            if (tri_count == MAX_TRI) begin
                stop_with_error("shader_stim.txt holds more triangles than the table can take");
            end
            for (int k = 0; k < 9; k++) begin
                tri_coord[tri_count][k] = c[k];
            end
            tri_color[tri_count] = c[9];
            tri_count++;
        end
        $fclose(fd);
        if (tri_count == 0) begin
            stop_with_error("shader_stim.txt holds no triangles");
        end
    endtask

    // one strobe and a valid_out check on every cycle up to the next triangle
    task automatic shade_triangle(input int idx);
        int idle;
        int gap;
        idle = int'($urandom % 4);
        gap = LATENCY + 2 + idle;
        @(posedge clk);
        data_valid_in <= 1'b1;
        v0_x <= COORD_W'(tri_coord[idx][0]);
        v0_y <= COORD_W'(tri_coord[idx][1]);
        v0_z <= COORD_W'(tri_coord[idx][2]);
        v1_x <= COORD_W'(tri_coord[idx][3]);
        v1_y <= COORD_W'(tri_coord[idx][4]);
        v1_z <= COORD_W'(tri_coord[idx][5]);
        v2_x <= COORD_W'(tri_coord[idx][6]);
        v2_y <= COORD_W'(tri_coord[idx][7]);
        v2_z <= COORD_W'(tri_coord[idx][8]);
        @(negedge clk);
        check_value("valid_out", int'(valid_out), 0);
        for (int j = 1; j <= gap; j++) begin
            @(posedge clk);
            data_valid_in <= 1'b0;
            @(negedge clk);
            check_value("valid_out", int'(valid_out), int'(j == LATENCY));
            if (j == LATENCY) begin
                check_value($sformatf("color_out (triangle %0d)", idx),
                            int'(color_out), tri_color[idx]);
            end
        end
    endtask

    // bound from the worst case spacing per triangle
    initial begin
        wait (vectors_loaded);
        #((tri_count * (LATENCY + 6) + 20) * 20);
        stop_with_error("timeout, the run did not finish in the expected time");
    end

    initial begin
        void'($urandom(89));
        rst_in = 1'b1;
        data_valid_in = 1'b0;
        v0_x = '0;
        v0_y = '0;
        v0_z = '0;
        v1_x = '0;
        v1_y = '0;
        v1_z = '0;
        v2_x = '0;
        v2_y = '0;
        v2_z = '0;
        read_triangles();
        vectors_loaded = 1'b1;
        repeat (2) @(posedge clk);
        rst_in <= 1'b0;
        // quiet outputs before the first triangle
        repeat (4) begin
            @(negedge clk);
            check_value("valid_out", int'(valid_out), 0);
            check_value("color_out", int'(color_out), 0);
        end
        for (int i = 0; i < tri_count; i++) begin
            shade_triangle(i);
        end
        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

// ==== shader_stim.txt ====
# v0_x v0_y v0_z v1_x v1_y v1_z v2_x v2_y v2_z expected_color
# signed decimal coordinates, one triangle per line
0 0 0 1 0 0 0 1 0 255
10 20 5 110 20 5 10 70 5 255
0 0 0 1 0 -5 0 1 0 0
0 0 0 1 0 -3 0 1 0 20
0 0 0 1 0 -2 0 1 -1 40
0 0 0 1 0 -2 0 1 0 60
0 0 0 2 0 -3 0 2 0 78
0 0 0 1 0 -1 0 1 -1 96
0 0 0 3 0 -3 0 3 -2 114
0 0 0 4 0 -3 0 4 -3 130
0 0 0 1 0 -1 0 1 0 146
0 0 0 5 0 -4 0 5 0 162
0 0 0 2 0 -1 0 2 -1 178
0 0 0 3 0 -2 0 3 0 194
100 -50 7 102 -50 6 100 -48 7 210
0 0 0 3 0 -1 0 3 -1 226
0 0 0 3 0 -1 0 3 0 242
0 0 0 4 0 -1 0 4 0 255
-20 -30 -40 -17 -30 -38 -20 -27 -39 178
1 2 3 4 6 5 2 7 9 60
0 0 0 0 1 0 1 0 0 255
0 0 0 0 1 0 1 0 -5 255
1 2 3 2 7 9 4 6 5 255
0 0 0 0 1 0 1 0 -1 255
0 0 0 1 0 0 0 0 1 0
0 0 0 1 1 1 2 2 2 0
5 5 5 5 5 5 7 8 9 0
-3 4 -5 -3 4 -5 -3 4 -5 0
10 -10 0 20 -20 0 -30 30 0 0
-32768 -32768 -32768 32767 32767 32767 0 0 0 0
-32768 -32768 32767 32767 -32768 -32768 -32768 32767 32767 146
-32768 -32768 32767 32767 -32768 -32768 -32768 32767 -32768 96
-32768 -32768 0 32767 -32768 0 -32768 32767 0 255
-32768 -32768 0 -32768 32767 0 32767 -32768 0 255
-32768 -32768 32767 -32768 32767 -32768 32767 -32768 -32768 255
0 0 32767 1 0 -32768 0 1 32767 0
-32768 -32768 10000 32767 -32768 -16214 -32768 32767 10000 226

// ==== src.f ====
shader_num_pkg.sv
shader_color_pkg.sv
normal_unit.sv
magnitude_unit.sv
shade_divider.sv
shade_lut.sv
flat_shader.sv
tb_flat_shader.sv

// ==== run.sh ====
#!/bin/sh
# build and run the flat shader testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal -f src.f --top-module tb_flat_shader -o tb_flat_shader
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

output=$(./obj_dir/tb_flat_shader 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qF 'All tests passed!'; then
    exit 0
fi
exit 1
